// ==== src/eqAudioPkg.sv ====
package eqAudioPkg;

	//////////////////////////////////////////////////
	// widths and counts
	//////////////////////////////////////////////////
	localparam int SAMPLE_WIDTH    = 24; // codec word, MSB first
	localparam int PRESCALER_WIDTH = 9;  // frame counter, one frame is 256 clk
	localparam int EQ_BANDS        = 4;
	localparam int GAIN_WIDTH      = 8;  // one band gain
	localparam int RESULT_WIDTH    = 8;  // byte returned to the host
	localparam int SYNC_STAGES     = 2;  // depth of pin synchronizers

	// bit slots inside a half frame
	localparam int FIRST_SLOT = 1;  // slot 0 carries no data
	localparam int LAST_SLOT  = 24;
	localparam int LATCH_SLOT = 25; // both channels complete here

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////
	typedef logic [SAMPLE_WIDTH-1:0] sample_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereoSample_t;

	// band3 arrives first over spi
	typedef struct packed {
		logic [GAIN_WIDTH-1:0] band3;
		logic [GAIN_WIDTH-1:0] band2;
		logic [GAIN_WIDTH-1:0] band1;
		logic [GAIN_WIDTH-1:0] band0;
	} eqGains_t;

	typedef logic [RESULT_WIDTH-1:0] result_t;

	// codec clocks plus strobes for the receiver
	typedef struct packed {
		logic                       bck;         // clk / 4
		logic                       lrck;        // clk / 256, high = right
		logic [PRESCALER_WIDTH-5:0] slot;        // bit slot in half frame
		logic                       shiftStrobe; // clk before bck rises
		logic                       frameStrobe; // latch point, once a frame
	} i2sTiming_t;

endpackage

// ==== src/i2sClockGen.sv ====
`timescale 1ns/1ps

module i2sClockGen (
	input  logic                   clk,
	input  logic                   reset,
	output eqAudioPkg::i2sTiming_t timing
);
	import eqAudioPkg::*;

	logic [PRESCALER_WIDTH-1:0] prescaler; // free running
	logic [1:0]                 phase;     // position inside one bck period
	logic [PRESCALER_WIDTH-5:0] slot;
	logic                       lrck;

	//////////////////////////////////////////////////
	// prescaler
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
			prescaler <= '0;
		else
			prescaler <= prescaler + 1'b1;
	end

	assign phase = prescaler[1:0];
	assign slot  = prescaler[PRESCALER_WIDTH-3:2]; // 32 slots per half frame
	assign lrck  = prescaler[PRESCALER_WIDTH-2];   // second half of frame high

	//////////////////////////////////////////////////
	// strobe decode
	//////////////////////////////////////////////////
	always_comb
	begin
		timing.bck  = prescaler[1];
		timing.lrck = lrck;
		timing.slot = slot;
		// phase 01 is the last clk before bck goes high
		timing.shiftStrobe = (phase == 2'b01) && (slot >= FIRST_SLOT) && (slot <= LAST_SLOT);
		// right channel done, left long since done
		timing.frameStrobe = lrck && (slot == LATCH_SLOT) && (phase == 2'b00);
	end

endmodule

// ==== src/i2sReceiver.sv ====
`timescale 1ns/1ps

module i2sReceiver (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      din,
	input  eqAudioPkg::i2sTiming_t    timing,
	output eqAudioPkg::stereoSample_t sample,
	output logic                      sampleValid
);
	import eqAudioPkg::*;

	sample_t leftShift;  // filled while lrck low
	sample_t rightShift; // filled while lrck high

	//////////////////////////////////////////////////
	// bit shifting
	//////////////////////////////////////////////////
	// din moved on bck fall, so it is settled by the strobe
	always_ff @(posedge clk)
	begin
		if (timing.shiftStrobe)
		begin
			if (timing.lrck)
				rightShift <= {rightShift[SAMPLE_WIDTH-2:0], din}; // msb first
			else
				leftShift <= {leftShift[SAMPLE_WIDTH-2:0], din};
		end
	end

	//////////////////////////////////////////////////
	// frame latch
	//////////////////////////////////////////////////
	// both channels copied together
	// sample never mixes two frames
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sample      <= '0;
			sampleValid <= 1'b0;
		end
		else
		begin
			sampleValid <= timing.frameStrobe; // one clk, once per frame
			if (timing.frameStrobe)
			begin
				sample.left  <= leftShift;
				sample.right <= rightShift;
			end
		end
	end

endmodule

// ==== src/spiPeripheral.sv ====
`timescale 1ns/1ps

module spiPeripheral (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 sck,
	input  logic                 sdi,
	input  logic                 done,
	input  eqAudioPkg::result_t  result,
	output eqAudioPkg::eqGains_t eqGains,
	output logic                 sdo
);
	import eqAudioPkg::*;

	logic [SYNC_STAGES-1:0] sckSync;  // sck into clk domain
	logic [SYNC_STAGES-1:0] sdiSync;  // sdi, same delay as sck
	logic                   sckLast;  // previous synced sck
	logic                   sckRise;
	logic                   sckFall;
	logic                   doneLast;
	logic                   doneRise;
	result_t                outShift; // readback shifter

	//////////////////////////////////////////////////
	// synchronizers and edge detect
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sckSync <= '0;
			sdiSync <= '0;
			sckLast <= 1'b0;
		end
		else
		begin
			sckSync <= {sckSync[SYNC_STAGES-2:0], sck};
			sdiSync <= {sdiSync[SYNC_STAGES-2:0], sdi};
			sckLast <= sckSync[SYNC_STAGES-1];
		end
	end

	assign sckRise = sckSync[SYNC_STAGES-1] & ~sckLast; // 3 clk after the pin
	assign sckFall = ~sckSync[SYNC_STAGES-1] & sckLast;

	//////////////////////////////////////////////////
	// gain word shift in
	//////////////////////////////////////////////////
	// first bit ends up in band3 msb
	always_ff @(posedge clk)
	begin
		if (reset)
			eqGains <= '0;
		else if (sckRise)
			eqGains <= {eqGains[EQ_BANDS*GAIN_WIDTH-2:0], sdiSync[SYNC_STAGES-1]};
	end

	//////////////////////////////////////////////////
	// result readback
	//////////////////////////////////////////////////
	assign doneRise = done & ~doneLast;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			doneLast <= 1'b0;
			outShift <= '0;
		end
		else
		begin
			doneLast <= done;
			if (doneRise)
				outShift <= result; // msb already on sdo this cycle
			else if (done && sckFall)
				outShift <= {outShift[RESULT_WIDTH-2:0], 1'b0}; // next bit for host
		end
	end

	// bypass so the msb is out before the host's first rising edge
	assign sdo = doneRise ? result[RESULT_WIDTH-1] : outShift[RESULT_WIDTH-1];

endmodule

// ==== src/eqCore.sv ====
`timescale 1ns/1ps

module eqCore (
	input  logic                clk,
	input  logic                reset,
	input  logic                load,
	input  eqAudioPkg::sample_t left,
	output eqAudioPkg::result_t result,
	output logic                done
);
	import eqAudioPkg::*;

	logic [SYNC_STAGES-1:0] loadSync;
	logic                   loadSynced; // load in clk domain

	// two flop synchronizer for the host's load pin
	always_ff @(posedge clk)
	begin
		if (reset)
			loadSync <= '0;
		else
			loadSync <= {loadSync[SYNC_STAGES-2:0], load};
	end

	assign loadSynced = loadSync[SYNC_STAGES-1];

	//////////////////////////////////////////////////
	// capture and done
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			done   <= 1'b0;
		end
		else if (loadSynced)
		begin
			result <= left[SAMPLE_WIDTH-1 -: RESULT_WIDTH]; // track top byte
			done   <= 1'b0;
		end
		else
			done <= 1'b1; // result frozen, 3 clk after the pin falls
	end

endmodule

// ==== src/eqAudioTop.sv ====
`timescale 1ns/1ps

module eqAudioTop (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      din,
	input  logic                      sck,
	input  logic                      sdi,
	input  logic                      load,
	output logic                      scki,
	output logic                      bck,
	output logic                      lrck,
	output logic                      sdo,
	output logic                      done,
	output logic                      sampleValid,
	output eqAudioPkg::stereoSample_t sample,
	output eqAudioPkg::eqGains_t      eqGains
);
	import eqAudioPkg::*;

	i2sTiming_t timing; // prescaler clocks and strobes
	result_t    result; // byte held for readback

	//////////////////////////////////////////////////
	// codec clocks
	//////////////////////////////////////////////////
	assign scki = clk; // 256 fs system clock
	assign bck  = timing.bck;
	assign lrck = timing.lrck;

	i2sClockGen clockGen (
		.clk    (clk),
		.reset  (reset),
		.timing (timing)
	);

	i2sReceiver receiver (
		.clk         (clk),
		.reset       (reset),
		.din         (din),
		.timing      (timing),
		.sample      (sample),
		.sampleValid (sampleValid)
	);

	//////////////////////////////////////////////////
	// host side
	//////////////////////////////////////////////////
	eqCore core (
		.clk    (clk),
		.reset  (reset),
		.load   (load),
		.left   (sample.left), // only left feeds the result
		.result (result),
		.done   (done)
	);

	spiPeripheral spiPort (
		.clk     (clk),
		.reset   (reset),
		.sck     (sck),
		.sdi     (sdi),
		.done    (done),
		.result  (result),
		.eqGains (eqGains),
		.sdo     (sdo)
	);

endmodule

// ==== dv/eqAudio_properties.sv ====
`timescale 1ns/1ps

module eqAudioProperties (
	input logic clk,
	input logic reset,
	input logic bck,
	input logic sampleValid,
	input logic done,
	input logic loadSynced
);
	logic [8:0] sinceValid; // clk cycles since last sampleValid
	logic       seenValid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sinceValid <= '0;
			seenValid  <= 1'b0;
		end
		else if (sampleValid)
		begin
			sinceValid <= '0;
			seenValid  <= 1'b1;
		end
		else if (sinceValid != 9'h1FF)
			sinceValid <= sinceValid + 9'd1; // saturates
	end

	//////////////////////////////////////////////////
	// strobes and clocking
	//////////////////////////////////////////////////
	validPulse: assert property (@(posedge clk) disable iff (reset)
		sampleValid |=> !sampleValid)
		else $error("sampleValid held longer than one cycle");

	validSpacing: assert property (@(posedge clk) disable iff (reset)
		(sampleValid && seenValid) |-> (sinceValid >= 9'd255))
		else $error("sampleValid repeated within 255 cycles");

	// two clean cycles after reset before checking the divider
	bckToggle: assert property (@(posedge clk)
		(!reset && !$past(reset) && !$past(reset, 2)) |-> (bck != $past(bck, 2)))
		else $error("bck not toggling every 2 clk");

	doneLow: assert property (@(posedge clk) disable iff (reset)
		loadSynced |=> !done)
		else $error("done high while load held");

endmodule

bind eqAudioTop eqAudioProperties props (
	.clk         (clk),
	.reset       (reset),
	.bck         (bck),
	.sampleValid (sampleValid),
	.done        (done),
	.loadSynced  (core.loadSynced)
);

// ==== dv/eqAudioTb.sv ====
`timescale 1ns/1ps

module eqAudioTb;
	import eqAudioPkg::*;

	logic          clk;
	logic          reset;
	logic          din;
	logic          sck;
	logic          sdi;
	logic          load;
	logic          scki;
	logic          bck;
	logic          lrck;
	logic          sdo;
	logic          done;
	logic          sampleValid;
	stereoSample_t sample;
	eqGains_t      eqGains;

	stereoSample_t txWord;         // frame the codec model sends
	stereoSample_t audioTable [6];
	eqGains_t      gainTable [4];
	stereoSample_t readSample [2]; // readback rows
	result_t       readByte [2];   // top byte of each row's left
	result_t       readValue;
	logic [31:0]   randomWord;
	int            cycles;
	int            period;

	eqAudioTop uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// error handling and compares
	//////////////////////////////////////////////////
	task automatic stopWithError(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic checkSample(input stereoSample_t got, input stereoSample_t exp,
		input string what);
		if (got !== exp)
			stopWithError($sformatf("Mismatch at %0d ns: %s, expected %h, got %h",
				$time, what, exp, got));
	endtask

	task automatic checkGains(input eqGains_t got, input eqGains_t exp, input string what);
		if (got !== exp)
			stopWithError($sformatf("Mismatch at %0d ns: %s, expected %h, got %h",
				$time, what, exp, got));
	endtask

	task automatic checkResult(input result_t got, input result_t exp, input string what);
		if (got !== exp)
			stopWithError($sformatf("Mismatch at %0d ns: %s, expected %h, got %h",
				$time, what, exp, got));
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stopWithError($sformatf("Mismatch at %0d ns: %s, expected %b, got %b",
				$time, what, exp, got));
	endtask

	task automatic checkCount(input int got, input int exp, input string what);
		if (got != exp)
			stopWithError($sformatf("Mismatch at %0d ns: %s, expected %0d, got %0d",
				$time, what, exp, got));
	endtask

	function automatic logic portLevel(input string name);
		case (name)
			"bck":         return bck;
			"lrck":        return lrck;
			"sampleValid": return sampleValid;
			default:       return done;
		endcase
	endfunction

	// counts falling clk edges until the port reads value
	task automatic waitLevel(input string name, input logic value, input int limit,
		output int count);
		count = 0;
		do
		begin
			if (count == limit)
				stopWithError($sformatf("timed out after %0d cycles waiting for %s",
					limit, name));
			@(negedge clk);
			count++;
		end
		while (portLevel(name) !== value);
	endtask

	//////////////////////////////////////////////////
	// spi host
	//////////////////////////////////////////////////
	task automatic writeGains(input eqGains_t word);
		logic [31:0] bits;
		bits = word;
		repeat ($bits(eqGains_t))
		begin
			@(posedge clk);
			sdi  <= bits[31]; // msb first while sck low
			bits = {bits[30:0], 1'b0};
			repeat (4) @(posedge clk);
			sck <= 1'b1;
			repeat (4) @(posedge clk);
			sck <= 1'b0;
		end
		repeat (4) @(posedge clk);
	endtask

	// sdo read just before each sck rise
	task automatic readResult(output result_t value);
		value = '0;
		repeat (RESULT_WIDTH)
		begin
			repeat (4) @(posedge clk);
			@(negedge clk);
			value = {value[RESULT_WIDTH-2:0], sdo};
			@(posedge clk);
			sck <= 1'b1;
			repeat (4) @(posedge clk);
			sck <= 1'b0;
		end
	endtask

	// codec model
	// next bit goes out one clk after bck falls
	// msb lands in slot 1
	initial
	begin
		logic    bckOld;
		logic    lrOld;
		logic    fell;
		logic    newHalf;
		sample_t codecShift;
		bckOld     = 1'b0;
		lrOld      = 1'b0;
		codecShift = '0;
		din <= 1'b0;
		forever
		begin
			@(negedge clk);
			fell   = bckOld && !bck;
			bckOld = bck;
			if (fell)
			begin
				newHalf = (lrck != lrOld); // lrck moves with bck at slot 0
				lrOld   = lrck;
				@(posedge clk);
				if (newHalf)
					codecShift = lrOld ? txWord.right : txWord.left;
				else
				begin
					din        <= codecShift[SAMPLE_WIDTH-1];
					codecShift = {codecShift[SAMPLE_WIDTH-2:0], 1'b0}; // zeros past the lsb
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial
	begin
		void'($urandom(75269));
		reset <= 1'b1;
		load  <= 1'b0;
		sck   <= 1'b0;
		sdi   <= 1'b0;
		txWord = '0;
		audioTable[0] = {24'h800001, 24'h7FFFFE}; // edge rows before the random ones
		audioTable[1] = {24'hFFFFFF, 24'h000000};
		for (int i = 2; i < 6; i++)
		begin
			randomWord = $urandom();
			audioTable[i].left = randomWord[23:0];
			randomWord = $urandom();
			audioTable[i].right = randomWord[23:0];
		end
		gainTable[0] = 32'h80C00103;
		gainTable[1] = 32'h5AA50FF0;
		gainTable[2] = $urandom();
		gainTable[3] = $urandom();
		readSample[0] = {24'hA51234, 24'h0F0F0F};
		readByte[0]   = 8'hA5;
		readSample[1] = {24'h3CBEEF, 24'hF00D00};
		readByte[1]   = 8'h3C;

		// outputs still held by reset
		repeat (9) @(posedge clk);
		@(negedge clk);
		checkSample(sample, '0, "sample in reset");
		checkGains(eqGains, '0, "gains in reset");
		checkBit(done, 1'b0, "done in reset");
		checkBit(sdo, 1'b0, "sdo in reset");
		checkBit(sampleValid, 1'b0, "sampleValid in reset");
		@(posedge clk);
		reset <= 1'b0;
		#1 checkBit(scki, 1'b1, "scki after clk rise");
		@(negedge clk);
		#1 checkBit(scki, 1'b0, "scki after clk fall");

		// clock periods counted on the ports
		waitLevel("bck", 1'b1, 8, cycles);
		waitLevel("bck", 1'b0, 8, cycles);
		period = cycles;
		waitLevel("bck", 1'b1, 8, cycles);
		checkCount(period + cycles, 4, "bck period");
		waitLevel("lrck", 1'b1, 300, cycles);
		waitLevel("lrck", 1'b0, 300, cycles);
		checkCount(cycles, 128, "lrck high time");
		waitLevel("lrck", 1'b1, 300, cycles);
		checkCount(cycles, 128, "lrck low time");

		foreach (audioTable[i])
		begin
			waitLevel("lrck", 1'b1, 300, cycles);
			waitLevel("lrck", 1'b0, 300, cycles);
			txWord = audioTable[i]; // frame starts at lrck fall
			waitLevel("sampleValid", 1'b1, 300, cycles);
			checkSample(sample, audioTable[i], $sformatf("audio row %0d", i));
		end

		foreach (gainTable[i])
		begin
			writeGains(gainTable[i]);
			@(negedge clk);
			// first byte sent lands in band3
			checkResult(eqGains.band3, gainTable[i][31:24], $sformatf("band3 of word %0d", i));
			checkGains(eqGains, gainTable[i], $sformatf("gain word %0d", i));
		end

		foreach (readSample[i])
		begin
			waitLevel("lrck", 1'b1, 300, cycles);
			waitLevel("lrck", 1'b0, 300, cycles);
			txWord = readSample[i]; // kept for this frame and the next
			waitLevel("sampleValid", 1'b1, 300, cycles);
			checkSample(sample, readSample[i], $sformatf("readback row %0d", i));
			@(posedge clk);
			load <= 1'b1;
			waitLevel("done", 1'b0, 4, cycles); // 3 clk after the load edge
			repeat (16) @(posedge clk);
			load <= 1'b0;
			waitLevel("done", 1'b1, 8, cycles);
			readResult(readValue);
			checkResult(readValue, readByte[i], $sformatf("readback byte %0d", i));
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== eqAudio.f ====
src/eqAudioPkg.sv
src/i2sClockGen.sv
src/i2sReceiver.sv
src/spiPeripheral.sv
src/eqCore.sv
src/eqAudioTop.sv
dv/eqAudio_properties.sv
dv/eqAudioTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the eqAudio testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
	--top-module eqAudioTb \
	--Mdir "$BUILD_DIR" \
	-f eqAudio.f

"./$BUILD_DIR/VeqAudioTb" 2>&1 | tee "$LOG_FILE"

if grep -q "Result: PASSED" "$LOG_FILE"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
